//--- verilog/song_pkg.sv
/* note types, the shortened song tables and the sequencer states
   shared by the sequencer, the note FIFO and the player */
`default_nettype none

package song_pkg;

  typedef logic [9:0] freq_t;     // hertz, zero plays a rest
  typedef logic [3:0] beats_t;
  typedef logic [2:0] part_t;     // 1 to 6, zero before the first note
  typedef logic [2:0] note_idx_t;
  typedef logic [9:0] millis_t;

  localparam int INTRO_LEN  = 4;
  localparam int VERSE_LEN  = 6;
  localparam int CHORUS_LEN = 6;

  localparam int LAST_PART  = 6;  // wraps back to part 1 after this

  // intro opening
  localparam freq_t INTRO_FREQ [INTRO_LEN] = '{
    10'd554, 10'd622, 10'd622, 10'd698
  };
  localparam beats_t INTRO_BEATS [INTRO_LEN] = '{
    4'd6, 4'd10, 4'd6, 4'd6
  };

  // verse notes after its leading rest, ends on a short rest
  localparam freq_t VERSE_FREQ [VERSE_LEN] = '{
    10'd277, 10'd277, 10'd277, 10'd277, 10'd311, 10'd0
  };
  localparam beats_t VERSE_BEATS [VERSE_LEN] = '{
    4'd1, 4'd1, 4'd1, 4'd1, 4'd2, 4'd1
  };

  // chorus opening
  localparam freq_t CHORUS_FREQ [CHORUS_LEN] = '{
    10'd466, 10'd466, 10'd415, 10'd415, 10'd698, 10'd698
  };
  localparam beats_t CHORUS_BEATS [CHORUS_LEN] = '{
    4'd1, 4'd1, 4'd1, 4'd1, 4'd3, 4'd3
  };

  typedef enum logic {
    SEQ_LOAD,   // fetch fields from the table
    SEQ_OFFER   // hold them on the valid/ready port
  } seq_state_t;

endpackage

`default_nettype wire

//--- verilog/panel_pkg.sv
/* timing and seven-segment types for the LED panel and the player's
   millisecond timer */
`default_nettype none

package panel_pkg;

  typedef logic [6:0]  seg_t;     // bit 0 is the top segment
  typedef logic [15:0] ticks_t;   // clocks inside one millisecond

  // digits 0 to 9, segments g down to a
  localparam seg_t DIGIT_SEG [10] = '{
    7'b0111111,
    7'b0000110,
    7'b1011011,
    7'b1001111,
    7'b1100110,
    7'b1101101,
    7'b1111100,
    7'b0000111,
    7'b1111111,
    7'b1100111
  };

endpackage

`default_nettype wire

//--- verilog/tone_synth.sv
/* square wave of freq hertz from a phase accumulator, silent when
   freq is zero, restarted at every note */
`default_nettype none

module tone_synth import song_pkg::*; #(
  parameter int TICKS_PER_MS = 10
) (
  input  logic  clk,
  input  logic  rst,
  input  freq_t freq,
  input  logic  restart,
  output logic  sound
);

  localparam logic [31:0] HALF_SEC = 32'(TICKS_PER_MS * 500);  // clocks in half a second

  logic [31:0] acc;
  logic [31:0] acc_next;

  assign acc_next = acc + 32'(freq);

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (freq == '0) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (acc_next >= HALF_SEC) begin
      acc   <= acc_next - HALF_SEC;
      sound <= !sound;  // two edges per period
    end else begin
      acc <= acc_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/led_panel.sv
/* registered seven-segment digit of the part number, dot on bit 7,
   dark until the first note arrives */
`default_nettype none

module led_panel import song_pkg::*; import panel_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  part_t      part,
  input  logic       dot,
  output logic [7:0] led
);

  seg_t digit;

  assign digit = DIGIT_SEG[part];

  always_ff @(posedge clk) begin
    if (rst) begin
      led <= '0;
    end else if (part == '0) begin
      led <= '0;  // nothing played yet
    end else begin
      led <= {dot, digit};
    end
  end

endmodule

`default_nettype wire

//--- verilog/note_sequencer.sv
/* walks intro, intro, verse, chorus, verse, chorus forever and offers
   one note at a time on a valid/ready port */
`default_nettype none

module note_sequencer import song_pkg::*; #(
  parameter int BEAT_MS = 100
) (
  input  logic    clk,
  input  logic    rst,
  output logic    note_valid,
  input  logic    note_ready,
  output freq_t   note_freq,
  output millis_t note_ms,
  output part_t   note_part
);

  seq_state_t state;
  part_t      part;
  note_idx_t  idx;
  part_t      next_part;
  note_idx_t  next_idx;
  logic       last_note;

  function automatic note_idx_t section_last(part_t p);
    case (p)
      3'd1, 3'd2: section_last = note_idx_t'(INTRO_LEN - 1);
      3'd3, 3'd5: section_last = note_idx_t'(VERSE_LEN - 1);
      default:    section_last = note_idx_t'(CHORUS_LEN - 1);
    endcase
  endfunction

  function automatic freq_t table_freq(part_t p, note_idx_t i);
    case (p)
      3'd1, 3'd2: table_freq = INTRO_FREQ[i[1:0]];
      3'd3, 3'd5: table_freq = VERSE_FREQ[i];
      default:    table_freq = CHORUS_FREQ[i];
    endcase
  endfunction

  function automatic millis_t table_ms(part_t p, note_idx_t i);
    beats_t beats;
    int     ms;
    case (p)
      3'd1, 3'd2: beats = INTRO_BEATS[i[1:0]];
      3'd3, 3'd5: beats = VERSE_BEATS[i];
      default:    beats = CHORUS_BEATS[i];
    endcase
    ms = int'(beats) * BEAT_MS;
    if (p == 3'd3 || p == 3'd5) begin
      ms = ms * 2;  // verse runs at half tempo
    end
    table_ms = millis_t'(ms);
  endfunction

  assign note_valid = (state == SEQ_OFFER);
  assign last_note  = (idx == section_last(part));
  assign next_idx   = last_note ? '0 : idx + 1'b1;
  assign next_part  = !last_note ? part :
                      (part == part_t'(LAST_PART)) ? part_t'(1) : part + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEQ_LOAD;
      part  <= part_t'(1);
      idx   <= '0;
    end else begin
      case (state)
        SEQ_LOAD: begin
          note_freq <= table_freq(part, idx);
          note_ms   <= table_ms(part, idx);
          note_part <= part;
          state     <= SEQ_OFFER;
        end
        SEQ_OFFER: begin
          if (note_ready) begin  // next note goes straight out
            part      <= next_part;
            idx       <= next_idx;
            note_freq <= table_freq(next_part, next_idx);
            note_ms   <= table_ms(next_part, next_idx);
            note_part <= next_part;
          end
        end
        default: state <= SEQ_LOAD;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/note_fifo.sv
/* circular buffer of notes between the sequencer and the player,
   valid/ready on both sides */
`default_nettype none

module note_fifo import song_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  output logic    in_ready,
  input  freq_t   in_freq,
  input  millis_t in_ms,
  input  part_t   in_part,
  output logic    out_valid,
  input  logic    out_ready,
  output freq_t   out_freq,
  output millis_t out_ms,
  output part_t   out_part
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  freq_t            freq_mem [FIFO_DEPTH];
  millis_t          ms_mem   [FIFO_DEPTH];
  part_t            part_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] p);
    bump = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign wr_en      = in_valid && in_ready;
  assign rd_en      = out_valid && out_ready;
  assign count_next = count + CNT_W'(wr_en) - CNT_W'(rd_en);
  assign out_valid  = (count != '0);
  assign out_freq   = freq_mem[rd_ptr];
  assign out_ms     = ms_mem[rd_ptr];
  assign out_part   = part_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= bump(wr_ptr);
      if (rd_en) rd_ptr <= bump(rd_ptr);
      count    <= count_next;
      in_ready <= (count_next != CNT_W'(FIFO_DEPTH));  // low once full
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      freq_mem[wr_ptr] <= in_freq;
      ms_mem[wr_ptr]   <= in_ms;
      part_mem[wr_ptr] <= in_part;
    end
  end

endmodule

`default_nettype wire

//--- verilog/note_player.sv
/* plays each accepted note as tone then gap, timed in milliseconds,
   and feeds the tone synthesizer and the LED panel */
`default_nettype none

module note_player import song_pkg::*; import panel_pkg::*; #(
  parameter int TICKS_PER_MS = 10
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       out_valid,
  output logic       out_ready,
  input  freq_t      out_freq,
  input  millis_t    out_ms,
  input  part_t      out_part,
  output logic [7:0] led,
  output logic       sound
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_TONE,
    PH_GAP
  } phase_t;

  phase_t  phase;
  ticks_t  tick_cnt;
  millis_t ms_cnt;
  millis_t tone_ms;
  millis_t gap_ms;
  millis_t phase_len;
  freq_t   tone_freq;
  freq_t   synth_freq;
  part_t   shown_part;
  logic    accept;
  logic    ms_done;
  logic    phase_done;
  logic    dot;

  assign out_ready  = (phase == PH_IDLE);
  assign accept     = out_valid && out_ready;
  assign phase_len  = (phase == PH_TONE) ? tone_ms : gap_ms;
  assign ms_done    = (tick_cnt == ticks_t'(TICKS_PER_MS - 1));
  assign phase_done = ms_done && (ms_cnt == phase_len - millis_t'(1));
  assign synth_freq = (phase == PH_TONE) ? tone_freq : '0;
  assign dot        = (phase == PH_TONE) && (tone_freq != '0);  // rests stay dark

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= PH_IDLE;
      tick_cnt   <= '0;
      ms_cnt     <= '0;
      shown_part <= '0;
    end else begin
      if (phase == PH_IDLE) begin
        tick_cnt <= '0;
        ms_cnt   <= '0;
      end else if (ms_done) begin
        tick_cnt <= '0;
        ms_cnt   <= phase_done ? '0 : ms_cnt + 1'b1;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end

      case (phase)
        PH_IDLE: begin
          if (accept) begin
            phase      <= PH_TONE;
            shown_part <= out_part;
          end
        end
        PH_TONE: if (phase_done) phase <= (gap_ms == '0) ? PH_IDLE : PH_GAP;
        PH_GAP:  if (phase_done) phase <= PH_IDLE;
        default: phase <= PH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tone_freq <= out_freq;
      tone_ms   <= out_ms;
      gap_ms    <= out_ms / millis_t'(3);  // gap is a third of the note
    end
  end

  tone_synth #(
    .TICKS_PER_MS(TICKS_PER_MS)
  ) u_synth (
    .clk    (clk),
    .rst    (rst),
    .freq   (synth_freq),
    .restart(accept),
    .sound  (sound)
  );

  led_panel u_panel (
    .clk (clk),
    .rst (rst),
    .part(shown_part),
    .dot (dot),
    .led (led)
  );

endmodule

`default_nettype wire

//--- verilog/music_top.sv
/* melody player top level, sequencer into note FIFO into player;
   timing parameters are set here */
`default_nettype none

module music_top import song_pkg::*; #(
  parameter int TICKS_PER_MS = 10,
  parameter int BEAT_MS      = 100,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic       clk,
  input  logic       rst,
  output logic [7:0] led,
  output logic       sound
);

  logic    note_valid;
  logic    note_ready;
  freq_t   note_freq;
  millis_t note_ms;
  part_t   note_part;
  logic    out_valid;
  logic    out_ready;
  freq_t   out_freq;
  millis_t out_ms;
  part_t   out_part;

  note_sequencer #(
    .BEAT_MS(BEAT_MS)
  ) u_seq (
    .clk       (clk),
    .rst       (rst),
    .note_valid(note_valid),
    .note_ready(note_ready),
    .note_freq (note_freq),
    .note_ms   (note_ms),
    .note_part (note_part)
  );

  note_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (note_valid),
    .in_ready (note_ready),
    .in_freq  (note_freq),
    .in_ms    (note_ms),
    .in_part  (note_part),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_freq (out_freq),
    .out_ms   (out_ms),
    .out_part (out_part)
  );

  note_player #(
    .TICKS_PER_MS(TICKS_PER_MS)
  ) u_player (
    .clk      (clk),
    .rst      (rst),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_freq (out_freq),
    .out_ms   (out_ms),
    .out_part (out_part),
    .led      (led),
    .sound    (sound)
  );

endmodule

`default_nettype wire

//--- dv/music_asserts.sv
/* concurrent checks bound into the note FIFO and the player on the
   valid/ready handshake, the ready rule and the silent output */
`default_nettype none

module music_asserts import song_pkg::*; #(
  parameter bit CHECK_SOUND = 1'b1
) (
  input logic    clk,
  input logic    rst,
  input logic    valid,
  input logic    ready,
  input freq_t   freq,
  input millis_t ms,
  input part_t   part,
  input logic    busy,
  input logic    tone,
  input logic    dot,
  input logic    sound
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // read by the testbench

  hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
    valid && !ready |=> valid && $stable(freq) && $stable(ms) && $stable(part))
    else begin
      fail_count = fail_count + 1;
      $error("note changed or withdrawn while the receiver was stalled");
    end

  ready_only_when_idle: assert property (@(posedge clk) disable iff (rst)
    busy |-> !ready)
    else begin
      fail_count = fail_count + 1;
      $error("ready high while the receiver could not take a note");
    end

  if (CHECK_SOUND) begin : g_sound
    // synth output lags the phase by one clock
    quiet_outside_tone: assert property (@(posedge clk) disable iff (rst)
      !tone && !$past(tone) && !dot |-> !sound)
      else begin
        fail_count = fail_count + 1;
        $error("sound active outside a tone phase");
      end
  end

endmodule

bind note_fifo music_asserts #(.CHECK_SOUND(1'b0)) fifo_checks (
  .clk(clk), .rst(rst), .valid(in_valid), .ready(in_ready),
  .freq(in_freq), .ms(in_ms), .part(in_part),
  .busy(count == FIFO_DEPTH),  // full
  .tone(1'b0), .dot(1'b0), .sound(1'b0)  // input side only
);

bind note_player music_asserts player_checks (
  .clk(clk), .rst(rst), .valid(out_valid), .ready(out_ready),
  .freq(out_freq), .ms(out_ms), .part(out_part),
  .busy(tick_cnt != '0 || ms_cnt != '0),  // millisecond timer running
  .tone(phase == PH_TONE), .dot(dot), .sound(sound)
);

`default_nettype wire

//--- dv/music_tb.sv
/* testbench for the melody player, checks note order, tone and gap
   timing, sound toggles and the LED digit against its own song table */
`default_nettype none

module music_tb import song_pkg::*; import panel_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TICKS_PER_MS = 10;
  localparam int BEAT_MS      = 4;
  localparam int FIFO_DEPTH   = 4;
  localparam int SONG_PARTS   = 6;
  localparam int NUM_NOTES    = 33;  // one loop plus the first note again

  // section melodies, hertz and beats
  localparam int INTRO_HZ [4]    = '{554, 622, 622, 698};
  localparam int INTRO_BEAT [4]  = '{6, 10, 6, 6};
  localparam int VERSE_HZ [6]    = '{277, 277, 277, 277, 311, 0};
  localparam int VERSE_BEAT [6]  = '{1, 1, 1, 1, 2, 1};
  localparam int CHORUS_HZ [6]   = '{466, 466, 415, 415, 698, 698};
  localparam int CHORUS_BEAT [6] = '{1, 1, 1, 1, 3, 3};

  logic        clk;
  logic        rst;
  logic [7:0]  led;
  logic        sound;
  logic        accept;
  logic        phase_end;
  part_t       exp_part [NUM_NOTES];
  freq_t       exp_freq [NUM_NOTES];
  millis_t     exp_ms   [NUM_NOTES];
  int          total_cycles;
  int          cycle_limit;
  int          cycle_count;
  logic [31:0] lfsr_state;

  music_top #(
    .TICKS_PER_MS(TICKS_PER_MS),
    .BEAT_MS     (BEAT_MS),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) dut (
    .clk  (clk),
    .rst  (rst),
    .led  (led),
    .sound(sound)
  );

  assign accept    = dut.out_valid && dut.out_ready;  // player takes a note
  assign phase_end = dut.u_player.phase_done;         // last cycle of tone or gap

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic draw_bits(input int count, output int value);
    value = 0;
    for (int b = 0; b < count; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  function automatic seg_t seg_for_part(input part_t p);
    case (p)
      3'd1:    seg_for_part = 7'b0000110;
      3'd2:    seg_for_part = 7'b1011011;
      3'd3:    seg_for_part = 7'b1001111;
      3'd4:    seg_for_part = 7'b1100110;
      3'd5:    seg_for_part = 7'b1101101;
      3'd6:    seg_for_part = 7'b1111100;  // six drawn without the top bar
      default: seg_for_part = 7'b0111111;
    endcase
  endfunction

  task automatic add_note(input int n, input int part, input int k);
    int hz;
    int beats;
    int ms;
    if (part <= 2) begin
      hz    = INTRO_HZ[k];
      beats = INTRO_BEAT[k];
    end else if (part == 3 || part == 5) begin
      hz    = VERSE_HZ[k];
      beats = VERSE_BEAT[k];
    end else begin
      hz    = CHORUS_HZ[k];
      beats = CHORUS_BEAT[k];
    end
    ms = beats * BEAT_MS;
    if (part == 3 || part == 5) begin
      ms = ms * 2;  // verse at half tempo
    end
    exp_part[n]  = part_t'(part);
    exp_freq[n]  = freq_t'(hz);
    exp_ms[n]    = millis_t'(ms);
    total_cycles = total_cycles + (ms + ms / 3) * TICKS_PER_MS;
  endtask

  task automatic build_table();
    int n;
    n = 0;
    total_cycles = 0;
    for (int p = 1; p <= SONG_PARTS; p++) begin
      for (int k = 0; k < ((p <= 2) ? 4 : 6); k++) begin
        add_note(n, p, k);
        n++;
      end
    end
    add_note(n, 1, 0);  // wraps to the first intro note
    cycle_limit = total_cycles + total_cycles / 10;
  endtask

  task automatic check_freq(input string name, input freq_t expected, input freq_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_ms(input string name, input millis_t expected, input millis_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual,
                             input int tol);
    if (actual < expected - tol || actual > expected + tol) begin
      $display("ERROR %s: expected %0d (+/- %0d), actual %0d", name, expected, tol, actual);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic wait_accept(input int idx, output int waited);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (idx == 0) begin  // nothing may show before the first note
        check_bit("startup sound", 1'b0, sound);
        check_seg("startup segments", '0, led[6:0]);
        check_bit("startup dot", 1'b0, led[7]);
      end
    end while (!accept);
  endtask

  task automatic play_note(input int i);
    int    waited;
    int    cyc;
    int    toggles;
    int    span;
    int    rnd;
    int    sample_at;
    logic  last_sound;
    string tag;
    tag = $sformatf("note %0d", i);
    wait_accept(i, waited);
    if (i > 0) begin
      check_count({tag, " start delay"}, 1, waited, 1);
    end
    check_freq({tag, " freq"}, exp_freq[i], dut.out_freq);
    check_ms({tag, " ms"}, exp_ms[i], dut.out_ms);
    span = int'(exp_ms[i]) * TICKS_PER_MS;
    draw_bits(10, rnd);
    sample_at  = 2 + rnd % (span - 1);  // led trails the note by two cycles
    last_sound = sound;
    cyc        = 0;
    toggles    = 0;
    do begin
      @(negedge clk);
      cyc++;
      if (sound !== last_sound) begin
        toggles++;
      end
      last_sound = sound;
      if (cyc == sample_at) begin
        check_seg({tag, " digit"}, seg_for_part(exp_part[i]), led[6:0]);
        check_bit({tag, " dot"}, exp_freq[i] != '0, led[7]);
      end
      if (exp_freq[i] == '0) begin
        check_bit({tag, " rest sound"}, 1'b0, sound);
        check_bit({tag, " rest dot"}, 1'b0, led[7]);
      end
    end while (!phase_end);
    check_count({tag, " tone cycles"}, span, cyc, 2);
    check_count({tag, " toggles"}, 2 * int'(exp_freq[i]) * int'(exp_ms[i]) / 1000,
                toggles, 1);
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while (!phase_end);
    check_count({tag, " gap cycles"}, (int'(exp_ms[i]) / 3) * TICKS_PER_MS, cyc, 2);
  endtask

  function automatic int assert_failures();
    assert_failures = dut.u_fifo.fifo_checks.fail_count
                    + dut.u_player.player_checks.fail_count;
  endfunction

  always @(negedge clk) begin
    if (assert_failures() != 0) begin
      $display("a bound assertion failed, see the assertion message above");
      $display("test failed");
      $fatal(1, "stopped at the first assertion failure");
    end
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the song did not finish within %0d cycles", cycle_limit);
    $display("test failed");
    $fatal(1, "simulation ran out of cycles");
  end

  initial begin
    rst        = 1'b1;
    lfsr_state = 32'he291;
    build_table();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_NOTES; i++) begin
      play_note(i);
    end
    if (assert_failures() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "bound assertions reported failures");
    end
  end

endmodule

`default_nettype wire

//--- files.f
verilog/song_pkg.sv
verilog/panel_pkg.sv
verilog/tone_synth.sv
verilog/led_panel.sv
verilog/note_sequencer.sv
verilog/note_fifo.sv
verilog/note_player.sv
verilog/music_top.sv
dv/music_asserts.sv
dv/music_tb.sv

//--- run.sh
#!/bin/sh
# builds the melody player testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module music_tb -f files.f -o music_sim > build.log 2>&1 &&
{ ./obj_dir/music_sim > sim.log 2>&1 || true; } &&
grep -qx "test passed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
